// ==== compile.f ====
logic/soc_pkg.sv
logic/bus_arbiter.sv
logic/near_router.sv
logic/memory_bank.sv
logic/peripheral_bridge.sv
logic/system_registers.sv
logic/interval_timer.sv
logic/soc_interconnect.sv
dv/soc_interconnect_chk.sv
dv/soc_interconnect_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = soc_interconnect_tb
FILELIST = compile.f
OBJ_DIR = obj_dir

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/soc_interconnect_tb.sv ====
module soc_interconnect_tb;
	import soc_pkg::*;

	localparam int ROM_READS = 100;
	localparam int ROM_WRITES = 10;
	localparam int RAM_OPS = 300;
	localparam int HOLE_READS = 10;
	localparam int REG_OPS = 12;
	localparam int MIX_OPS = 200;
	localparam int TRANSFERS = ROM_READS + 2 * ROM_WRITES + RAM_OPS + 2 * HOLE_READS
		+ REG_OPS + MIX_OPS;
	localparam int CYCLE_LIMIT = 40 * TRANSFERS + 2000;

	logic clock;
	logic reset;
	logic pa_request;
	bus_addr_t pa_address;
	logic pa_ready;
	logic [31:0] pa_rdata;
	logic pb_request;
	logic pb_rw;
	bus_addr_t pb_address;
	logic [31:0] pb_wdata;
	logic pb_ready;
	logic [31:0] pb_rdata;
	logic pc_request;
	logic pc_rw;
	bus_addr_t pc_address;
	logic [31:0] pc_wdata;
	logic pc_ready;
	logic [31:0] pc_rdata;
	logic [7:0] leds;
	logic timer_interrupt;

	// Reference state
	logic [31:0] ram_model [256];
	bit ram_written [256];
	integer seed = 32'h20d;
	int checks = 0;
	int errors = 0;
	int errors_before = 0;
	int cycles = 0;

	soc_interconnect i_dut (
		.i_clock(clock), .i_reset(reset),
		.i_pa_request(pa_request), .i_pa_address(pa_address),
		.o_pa_ready(pa_ready), .o_pa_rdata(pa_rdata),
		.i_pb_request(pb_request), .i_pb_rw(pb_rw), .i_pb_address(pb_address),
		.i_pb_wdata(pb_wdata), .o_pb_ready(pb_ready), .o_pb_rdata(pb_rdata),
		.i_pc_request(pc_request), .i_pc_rw(pc_rw), .i_pc_address(pc_address),
		.i_pc_wdata(pc_wdata), .o_pc_ready(pc_ready), .o_pc_rdata(pc_rdata),
		.o_leds(leds), .o_timer_interrupt(timer_interrupt)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, a transfer never completed", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	function automatic logic [31:0] draw();
		return $random(seed);
	endfunction

	// Word k of the boot image holds k * stride + base with k taken modulo the ROM depth
	function automatic logic [31:0] rom_rule(input logic [27:0] offset);
		logic [31:0] k;
		k = {4'h0, offset} >> 2;
		k = k % ROM_WORDS;
		return k * ROM_STRIDE + ROM_BASE_VALUE;
	endfunction

	function automatic logic [31:0] far_addr(input logic [3:0] device, input logic [21:0] word);
		return {REGION_BRIDGE, device, word, 2'b00};
	endfunction

	task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s gave %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("%s done, %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	// Each port holds its request until ready is seen at a falling edge
	task automatic instr_read(input logic [31:0] addr, output logic [31:0] rdata);
		pa_request = 1'b1;
		pa_address = addr;
		do @(negedge clock); while (!pa_ready);
		rdata = pa_rdata;
		pa_request = 1'b0;
	endtask

	task automatic data_access(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		pb_request = 1'b1;
		pb_rw = rw;
		pb_address = addr;
		pb_wdata = wdata;
		do @(negedge clock); while (!pb_ready);
		rdata = pb_rdata;
		pb_request = 1'b0;
	endtask

	task automatic dma_access(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		pc_request = 1'b1;
		pc_rw = rw;
		pc_address = addr;
		pc_wdata = wdata;
		do @(negedge clock); while (!pc_ready);
		rdata = pc_rdata;
		pc_request = 1'b0;
	endtask

	// Random RAM read or write in one half with upper offset bits exercising the wrap
	task automatic ram_op(input logic upper_half);
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] d;
		logic [7:0] slot;
		logic [31:0] addr;
		logic rw;
		r = draw();
		w = draw();
		slot = {upper_half, r[6:0]};
		addr = {REGION_RAM, r[31:14], slot, 2'b00};
		rw = !ram_written[slot] || r[7];
		if (rw) begin
			ram_model[slot] = w;
			ram_written[slot] = 1'b1;
		end
		if (upper_half)
			dma_access(rw, addr, w, d);
		else
			data_access(rw, addr, w, d);
		if (!rw)
			compare_word(d, ram_model[slot], upper_half ? "dma ram read" : "data ram read");
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] d;
		logic [31:0] addr;
		int waited;
		reset = 1'b1;
		pa_request = 1'b0;
		pa_address = '0;
		pb_request = 1'b0;
		pb_rw = 1'b0;
		pb_address = '0;
		pb_wdata = '0;
		pc_request = 1'b0;
		pc_rw = 1'b0;
		pc_address = '0;
		pc_wdata = '0;
		repeat (2) @(negedge clock);
		reset = 1'b0;

		repeat (ROM_READS) begin
			r = draw();
			addr = {REGION_ROM, r[27:2], 2'b00};
			instr_read(addr, d);
			compare_word(d, rom_rule(addr[27:0]), "rom read");
		end
		repeat (ROM_WRITES) begin
			r = draw();
			addr = {REGION_ROM, r[27:2], 2'b00};
			data_access(1'b1, addr, draw(), d);
			instr_read(addr, d);
			compare_word(d, rom_rule(addr[27:0]), "rom read after write");
		end
		report_test("rom");

		fork
			repeat (RAM_OPS / 2) ram_op(1'b0);
			repeat (RAM_OPS / 2) ram_op(1'b1);
		join
		report_test("ram_shared");

		// Holes in the region map, then holes behind the bridge
		repeat (HOLE_READS) begin
			do r = draw(); while (r[3:0] == REGION_ROM || r[3:0] == REGION_RAM
				|| r[3:0] == REGION_BRIDGE);
			addr = {r[3:0], r[31:6], 2'b00};
			instr_read(addr, d);
			compare_word(d, 32'h0, "unmapped region");
		end
		repeat (HOLE_READS) begin
			do r = draw(); while (r[3:0] == DEV_TIMER || r[3:0] == DEV_SYSREG);
			data_access(1'b0, {REGION_BRIDGE, r[3:0], r[31:10], 2'b00}, '0, d);
			compare_word(d, 32'h0, "unmapped device");
		end
		report_test("unmapped");

		data_access(1'b0, far_addr(DEV_SYSREG, REG_ID), '0, d);
		compare_word(d, 32'd6, "device id");
		w = draw();
		data_access(1'b1, far_addr(DEV_SYSREG, REG_LEDS), w, d);
		compare_word({24'h0, leds}, {24'h0, w[7:0]}, "o_leds");
		data_access(1'b0, far_addr(DEV_SYSREG, REG_LEDS), '0, d);
		compare_word(d, {24'h0, w[7:0]}, "leds register");
		w = draw();
		data_access(1'b1, far_addr(DEV_SYSREG, REG_SCRATCH), w, d);
		data_access(1'b0, far_addr(DEV_SYSREG, REG_SCRATCH), '0, d);
		compare_word(d, w, "scratch register");
		report_test("system_registers");

		w = draw() & 32'h0fff_ffff;
		data_access(1'b1, far_addr(DEV_TIMER, REG_COUNT), w, d);
		data_access(1'b0, far_addr(DEV_TIMER, REG_COUNT), '0, d);
		checks++;
		assert (d >= w) else begin
			$display("Mismatch at %0t: count read %h is below the loaded %h", $time, d, w);
			errors++;
		end
		data_access(1'b0, far_addr(DEV_TIMER, REG_COUNT), '0, d);
		data_access(1'b1, far_addr(DEV_TIMER, REG_COMPARE), d + 32'd200, r);
		data_access(1'b1, far_addr(DEV_TIMER, REG_CONTROL), 32'h1, r);
		waited = 0;
		while (!timer_interrupt && waited < 400) begin
			@(negedge clock);
			waited++;
		end
		checks++;
		assert (timer_interrupt) else begin
			$display("Timer interrupt did not rise within 400 cycles of enabling it");
			errors++;
		end
		data_access(1'b0, far_addr(DEV_TIMER, REG_CONTROL), '0, d);
		compare_word(d & 32'h2, 32'h2, "timer pending bit");
		data_access(1'b1, far_addr(DEV_TIMER, REG_CONTROL), 32'h0, d);
		compare_word({31'h0, timer_interrupt}, 32'h0, "o_timer_interrupt");
		report_test("timer");

		// All three masters compete with random idle gaps
		fork
			begin : fetch_stream
				logic [31:0] fr;
				logic [31:0] fd;
				repeat (67) begin
					fr = draw();
					repeat (fr[1:0]) @(negedge clock);
					instr_read({REGION_ROM, fr[29:4], 2'b00}, fd);
					compare_word(fd, rom_rule({fr[29:4], 2'b00}), "mixed rom read");
				end
			end
			begin : data_stream
				logic [31:0] gr;
				repeat (67) begin
					gr = draw();
					repeat (gr[1:0]) @(negedge clock);
					ram_op(1'b0);
				end
			end
			begin : dma_stream
				logic [31:0] hr;
				repeat (66) begin
					hr = draw();
					repeat (hr[1:0]) @(negedge clock);
					ram_op(1'b1);
				end
			end
		join
		report_test("three_masters");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dv/soc_interconnect_chk.sv ====
module soc_interconnect_chk (
	input logic        i_clock,
	input logic        i_reset,
	input logic        i_pa_request,
	input logic        i_pb_request,
	input logic        i_pc_request,
	input logic        i_pa_ready,
	input logic        i_pb_ready,
	input logic        i_pc_ready,
	input logic        i_bus_request,
	input logic        i_bus_rw,
	input logic [31:0] i_bus_address,
	input logic        i_bus_ready
);

	// ============================================================
	// Arbiter handshake
	// ============================================================

	single_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0({i_pa_ready, i_pb_ready, i_pc_ready}))
		else $error("more than one master ready in one cycle");

	// Bus must not move under a waiting request
	bus_steady: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !i_bus_ready |=> $stable(i_bus_address) && $stable(i_bus_rw))
		else $error("bus address or rw changed while the request waited");

	// The port drops its request in its ready cycle, so look one cycle back
	a_ready_owned: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_pa_request |=> !i_pa_ready)
		else $error("port A ready without a request");
	b_ready_owned: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_pb_request |=> !i_pb_ready)
		else $error("port B ready without a request");
	c_ready_owned: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_pc_request |=> !i_pc_ready)
		else $error("port C ready without a request");

endmodule

bind bus_arbiter soc_interconnect_chk u_chk (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_pa_request(i_pa_request),
	.i_pb_request(i_pb_request),
	.i_pc_request(i_pc_request),
	.i_pa_ready(o_pa_ready),
	.i_pb_ready(o_pb_ready),
	.i_pc_ready(o_pc_ready),
	.i_bus_request(o_bus_request),
	.i_bus_rw(o_bus_rw),
	.i_bus_address(o_bus_address),
	.i_bus_ready(i_bus_ready)
);

// ==== logic/soc_interconnect.sv ====
module soc_interconnect (
	input  logic                      i_clock,
	input  logic                      i_reset,

	// Instruction port
	input  logic                      i_pa_request,
	input  soc_pkg::bus_addr_t        i_pa_address,
	output logic                      o_pa_ready,
	output logic [soc_pkg::DATA_W-1:0] o_pa_rdata,

	// Data port
	input  logic                      i_pb_request,
	input  logic                      i_pb_rw,
	input  soc_pkg::bus_addr_t        i_pb_address,
	input  logic [soc_pkg::DATA_W-1:0] i_pb_wdata,
	output logic                      o_pb_ready,
	output logic [soc_pkg::DATA_W-1:0] o_pb_rdata,

	// DMA port
	input  logic                      i_pc_request,
	input  logic                      i_pc_rw,
	input  soc_pkg::bus_addr_t        i_pc_address,
	input  logic [soc_pkg::DATA_W-1:0] i_pc_wdata,
	output logic                      o_pc_ready,
	output logic [soc_pkg::DATA_W-1:0] o_pc_rdata,

	output logic [7:0]                o_leds,
	output logic                      o_timer_interrupt
);
	import soc_pkg::*;

	// Shared bus
	logic              bus_request;
	logic              bus_rw;
	bus_addr_t         bus_address;
	logic [DATA_W-1:0] bus_wdata;
	logic [DATA_W-1:0] bus_rdata;
	logic              bus_ready;

	// Near side targets
	logic              mem_request;
	logic              mem_ready;
	logic [DATA_W-1:0] mem_rdata;
	logic              near_request;
	logic              near_ready;
	logic [DATA_W-1:0] near_rdata;

	// Far side of the bridge
	logic              far_rw;
	logic [23:0]       far_offset;
	logic [DATA_W-1:0] far_wdata;
	logic              sysreg_request;
	logic              sysreg_ready;
	logic [DATA_W-1:0] sysreg_rdata;
	logic              timer_request;
	logic              timer_ready;
	logic [DATA_W-1:0] timer_rdata;

	bus_arbiter u_arbiter (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_pa_request(i_pa_request), .i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready), .o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request), .i_pb_rw(i_pb_rw), .i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata), .o_pb_ready(o_pb_ready), .o_pb_rdata(o_pb_rdata),
		.i_pc_request(i_pc_request), .i_pc_rw(i_pc_rw), .i_pc_address(i_pc_address),
		.i_pc_wdata(i_pc_wdata), .o_pc_ready(o_pc_ready), .o_pc_rdata(o_pc_rdata),
		.o_bus_request(bus_request), .o_bus_rw(bus_rw), .o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata), .i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
	);

	near_router u_router (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(bus_request), .i_address(bus_address),
		.o_ready(bus_ready), .o_rdata(bus_rdata),
		.o_mem_request(mem_request), .i_mem_ready(mem_ready), .i_mem_rdata(mem_rdata),
		.o_near_request(near_request), .i_near_ready(near_ready), .i_near_rdata(near_rdata)
	);

	memory_bank u_memory (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(mem_request), .i_rw(bus_rw), .i_address(bus_address),
		.i_wdata(bus_wdata), .o_ready(mem_ready), .o_rdata(mem_rdata)
	);

	peripheral_bridge u_bridge (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_near_request(near_request), .i_rw(bus_rw), .i_address(bus_address),
		.i_wdata(bus_wdata), .o_near_ready(near_ready), .o_near_rdata(near_rdata),
		.o_far_rw(far_rw), .o_far_offset(far_offset), .o_far_wdata(far_wdata),
		.o_sysreg_request(sysreg_request), .i_sysreg_ready(sysreg_ready),
		.i_sysreg_rdata(sysreg_rdata),
		.o_timer_request(timer_request), .i_timer_ready(timer_ready),
		.i_timer_rdata(timer_rdata)
	);

	system_registers u_sysreg (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(sysreg_request), .i_rw(far_rw), .i_offset(far_offset),
		.i_wdata(far_wdata), .o_ready(sysreg_ready), .o_rdata(sysreg_rdata),
		.o_leds(o_leds)
	);

	interval_timer u_timer (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(timer_request), .i_rw(far_rw), .i_offset(far_offset),
		.i_wdata(far_wdata), .o_ready(timer_ready), .o_rdata(timer_rdata),
		.o_interrupt(o_timer_interrupt)
	);

endmodule

// ==== logic/interval_timer.sv ====
module interval_timer (
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  logic [23:0]                i_offset,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic                       o_ready,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic                       o_interrupt
);
	import soc_pkg::*;

	logic [DATA_W-1:0] counter;
	logic [DATA_W-1:0] compare;
	logic enable;
	logic pending;

	wire [21:0] word = i_offset[23:2];
	wire access = i_request && !o_ready;
	wire write = access && i_rw;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			counter <= '0;
			compare <= '0;
			enable <= 1'b0;
			pending <= 1'b0;
		end else begin
			o_ready <= access;
			counter <= counter + 1'b1;
			if (enable && counter == compare)
				pending <= 1'b1;
			if (write && word == REG_COUNT)
				counter <= i_wdata;
			if (write && word == REG_COMPARE)
				compare <= i_wdata;
			// Any control write acknowledges the interrupt
			if (write && word == REG_CONTROL) begin
				enable <= i_wdata[0];
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			case (word)
				REG_COUNT: o_rdata <= counter;
				REG_COMPARE: o_rdata <= compare;
				REG_CONTROL: o_rdata <= {{(DATA_W-2){1'b0}}, pending, enable};
				default: o_rdata <= '0;
			endcase
		end
	end

	assign o_interrupt = pending;

endmodule

// ==== logic/system_registers.sv ====
module system_registers (
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  logic [23:0]                i_offset,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic                       o_ready,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic [7:0]                 o_leds
);
	import soc_pkg::*;

	logic [DATA_W-1:0] scratch;

	wire [21:0] word = i_offset[23:2];
	wire access = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_leds <= 8'h00;
		end else begin
			o_ready <= access;
			if (access && i_rw && word == REG_LEDS)
				o_leds <= i_wdata[7:0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_rw && word == REG_SCRATCH)
				scratch <= i_wdata;
			case (word)
				REG_ID: o_rdata <= DEVICE_ID;
				REG_LEDS: o_rdata <= {{(DATA_W-8){1'b0}}, o_leds};
				REG_SCRATCH: o_rdata <= scratch;
				default: o_rdata <= '0;
			endcase
		end
	end

endmodule

// ==== logic/peripheral_bridge.sv ====
module peripheral_bridge (
	input  logic                       i_clock,
	input  logic                       i_reset,

	input  logic                       i_near_request,
	input  logic                       i_rw,
	input  soc_pkg::bus_addr_t         i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic                       o_near_ready,
	output logic [soc_pkg::DATA_W-1:0] o_near_rdata,

	output logic                       o_far_rw,
	output logic [23:0]                o_far_offset,
	output logic [soc_pkg::DATA_W-1:0] o_far_wdata,

	output logic                       o_sysreg_request,
	input  logic                       i_sysreg_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_sysreg_rdata,
	output logic                       o_timer_request,
	input  logic                       i_timer_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_timer_rdata
);
	import soc_pkg::*;

	logic far_busy;
	logic [3:0] far_device;
	logic miss_ready;
	logic far_ready;
	logic [DATA_W-1:0] far_rdata;

	wire sysreg_select = (far_device == DEV_SYSREG);
	wire timer_select = (far_device == DEV_TIMER);

	// Idle only once the near side has seen its ready
	wire accept = i_near_request && !far_busy && !o_near_ready;

	// ============================================================
	// Far transaction
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			far_busy <= 1'b0;
			o_near_ready <= 1'b0;
			miss_ready <= 1'b0;
		end else begin
			o_near_ready <= far_busy && far_ready;
			miss_ready <= far_busy && !sysreg_select && !timer_select && !miss_ready;
			if (accept)
				far_busy <= 1'b1;
			else if (far_ready)
				far_busy <= 1'b0;
		end
	end

	// Latched copy of the near request
	always_ff @(posedge i_clock) begin
		if (accept) begin
			far_device <= i_address.far.device;
			o_far_offset <= i_address.far.offset;
			o_far_rw <= i_rw;
			o_far_wdata <= i_wdata;
		end
		if (far_busy && far_ready)
			o_near_rdata <= far_rdata;
	end

	assign o_sysreg_request = far_busy && sysreg_select;
	assign o_timer_request = far_busy && timer_select;

	// Unknown devices answer zero
	always_comb begin
		if (sysreg_select) begin
			far_ready = i_sysreg_ready;
			far_rdata = i_sysreg_rdata;
		end else if (timer_select) begin
			far_ready = i_timer_ready;
			far_rdata = i_timer_rdata;
		end else begin
			far_ready = miss_ready;
			far_rdata = '0;
		end
	end

endmodule

// ==== logic/memory_bank.sv ====
module memory_bank (
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  soc_pkg::bus_addr_t         i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic                       o_ready,
	output logic [soc_pkg::DATA_W-1:0] o_rdata
);
	import soc_pkg::*;

	logic [DATA_W-1:0] ram [RAM_WORDS];
	logic [$clog2(ROM_WORDS)-1:0] rom_index;
	logic [$clog2(RAM_WORDS)-1:0] ram_index;
	logic [DATA_W-1:0] rom_word;

	// Upper offset bits fold back onto the word arrays
	assign rom_index = i_address.near.offset[$clog2(ROM_WORDS)+1:2];
	assign ram_index = i_address.near.offset[$clog2(RAM_WORDS)+1:2];

	// Boot image is a fixed arithmetic sequence
	assign rom_word = DATA_W'(rom_index) * ROM_STRIDE + ROM_BASE_VALUE;

	wire is_rom = (i_address.near.region == REGION_ROM);
	wire access = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_ready <= 1'b0;
		else
			o_ready <= access;
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			// ROM ignores writes
			if (i_rw && !is_rom)
				ram[ram_index] <= i_wdata;
			o_rdata <= is_rom ? rom_word : ram[ram_index];
		end
	end

endmodule

// ==== logic/near_router.sv ====
module near_router (
	input  logic                       i_clock,
	input  logic                       i_reset,

	input  logic                       i_request,
	input  soc_pkg::bus_addr_t         i_address,
	output logic                       o_ready,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,

	output logic                       o_mem_request,
	input  logic                       i_mem_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_mem_rdata,

	output logic                       o_near_request,
	input  logic                       i_near_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_near_rdata
);
	import soc_pkg::*;

	logic miss_ready;

	wire [3:0] region = i_address.near.region;
	// ROM and RAM share one target and the bank tells them apart
	wire mem_select = (region == REGION_ROM) || (region == REGION_RAM);
	wire bridge_select = (region == REGION_BRIDGE);

	assign o_mem_request = i_request && mem_select;
	assign o_near_request = i_request && bridge_select;

	// Late zero answer for holes in the map
	always_ff @(posedge i_clock) begin
		if (i_reset)
			miss_ready <= 1'b0;
		else
			miss_ready <= i_request && !mem_select && !bridge_select && !miss_ready;
	end

	always_comb begin
		if (mem_select) begin
			o_ready = i_mem_ready;
			o_rdata = i_mem_rdata;
		end else if (bridge_select) begin
			o_ready = i_near_ready;
			o_rdata = i_near_rdata;
		end else begin
			o_ready = miss_ready;
			o_rdata = '0;
		end
	end

endmodule

// ==== logic/bus_arbiter.sv ====
module bus_arbiter (
	input  logic                       i_clock,
	input  logic                       i_reset,

	input  logic                       i_pa_request,
	input  soc_pkg::bus_addr_t         i_pa_address,
	output logic                       o_pa_ready,
	output logic [soc_pkg::DATA_W-1:0] o_pa_rdata,

	input  logic                       i_pb_request,
	input  logic                       i_pb_rw,
	input  soc_pkg::bus_addr_t         i_pb_address,
	input  logic [soc_pkg::DATA_W-1:0] i_pb_wdata,
	output logic                       o_pb_ready,
	output logic [soc_pkg::DATA_W-1:0] o_pb_rdata,

	input  logic                       i_pc_request,
	input  logic                       i_pc_rw,
	input  soc_pkg::bus_addr_t         i_pc_address,
	input  logic [soc_pkg::DATA_W-1:0] i_pc_wdata,
	output logic                       o_pc_ready,
	output logic [soc_pkg::DATA_W-1:0] o_pc_rdata,

	output logic                       o_bus_request,
	output logic                       o_bus_rw,
	output soc_pkg::bus_addr_t         o_bus_address,
	output logic [soc_pkg::DATA_W-1:0] o_bus_wdata,
	input  logic                       i_bus_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_bus_rdata
);
	import soc_pkg::*;

	logic grant_a;
	logic grant_b;
	logic grant_c;
	logic [DATA_W-1:0] response_data;

	// A request still high in its own ready cycle is the finished one
	wire pending_a = i_pa_request && !o_pa_ready;
	wire pending_b = i_pb_request && !o_pb_ready;
	wire pending_c = i_pc_request && !o_pc_ready;
	wire busy = grant_a || grant_b || grant_c;

	// Fixed priority B over A over C with the grant held until the bus answers
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			grant_a <= 1'b0;
			grant_b <= 1'b0;
			grant_c <= 1'b0;
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
			o_pc_ready <= 1'b0;
		end else begin
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
			o_pc_ready <= 1'b0;
			if (!busy) begin
				grant_b <= pending_b;
				grant_a <= !pending_b && pending_a;
				grant_c <= !pending_b && !pending_a && pending_c;
			end else if (i_bus_ready) begin
				grant_a <= 1'b0;
				grant_b <= 1'b0;
				grant_c <= 1'b0;
				o_pa_ready <= grant_a;
				o_pb_ready <= grant_b;
				o_pc_ready <= grant_c;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (busy && i_bus_ready)
			response_data <= i_bus_rdata;
	end

	// Read data shows only at the port being answered
	assign o_pa_rdata = o_pa_ready ? response_data : '0;
	assign o_pb_rdata = o_pb_ready ? response_data : '0;
	assign o_pc_rdata = o_pc_ready ? response_data : '0;

	assign o_bus_request = busy;
	// Instruction port only reads
	assign o_bus_rw = grant_b ? i_pb_rw : (grant_c ? i_pc_rw : 1'b0);
	assign o_bus_address = grant_b ? i_pb_address : (grant_c ? i_pc_address : i_pa_address);
	assign o_bus_wdata = grant_c ? i_pc_wdata : i_pb_wdata;

endmodule

// ==== logic/soc_pkg.sv ====
package soc_pkg;

	// ============================================================
	// Bus geometry
	// ============================================================

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// One address word, seen from the near bus or from behind the bridge
	typedef union packed {
		struct packed {
			logic [3:0]  region;
			logic [27:0] offset;
		} near;
		struct packed {
			logic [3:0]  region;
			logic [3:0]  device;
			logic [23:0] offset;
		} far;
	} bus_addr_t;

	// ============================================================
	// Address map
	// ============================================================

	localparam logic [3:0] REGION_ROM    = 4'h0;
	localparam logic [3:0] REGION_RAM    = 4'h2;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;

	localparam logic [3:0] DEV_TIMER  = 4'h5;
	localparam logic [3:0] DEV_SYSREG = 4'h9;

	// Memory contents and sizes
	localparam int ROM_WORDS = 64;
	localparam logic [DATA_W-1:0] ROM_STRIDE     = 32'h01010101;
	localparam logic [DATA_W-1:0] ROM_BASE_VALUE = 32'h00c0ffee;
	localparam int RAM_WORDS = 256;

	// Device registers as word indices into the 24-bit far offset
	localparam logic [DATA_W-1:0] DEVICE_ID = 32'd6;
	localparam logic [21:0] REG_ID      = 22'd0;
	localparam logic [21:0] REG_LEDS    = 22'd1;
	localparam logic [21:0] REG_SCRATCH = 22'd2;
	localparam logic [21:0] REG_COUNT   = 22'd0;
	localparam logic [21:0] REG_COMPARE = 22'd1;
	localparam logic [21:0] REG_CONTROL = 22'd2;

endpackage
